// File: hdl/audio_link_config.svh
// counts, widths and limits for the audio sample link
// and the volume control, shared by packages and RTL
`ifndef AUDIO_LINK_CONFIG_SVH
`define AUDIO_LINK_CONFIG_SVH

// pcm sample and xor key width
`define AUDIO_BITS 8

// volume register width, value after reset, upper limit
`define VOLUME_BITS 5
`define VOLUME_RESET 8
`define VOLUME_MAX 31

// stable cycles before a button change is passed on
// kept small by default, real buttons need far more
`define DEBOUNCE_CYCLES 16

// clocks per bit on the wire and strobe pulse length
`define BIT_CYCLES 16
`define STROBE_CYCLES 8

// low history and high history that make a strobe count
`define SETTLE_CYCLES 5

// ones needed out of 2*MAJORITY-1 samples to decide a 1
`define MAJORITY 3

// data changes without a strobe that mark the end of a word
`define END_TOGGLES 7

`endif

// File: hdl/audio_pkg.sv
// audio-side types: pcm sample, xor key, volume level
`include "audio_link_config.svh"

package audio_pkg;

  // one pcm sample as it enters or leaves the link
  typedef logic [`AUDIO_BITS-1:0] sample_t;

  // key applied on both sides of the wire
  // same width as the sample, bit for bit
  typedef logic [`AUDIO_BITS-1:0] key_t;

  // volume level stepped by the buttons
  typedef logic [`VOLUME_BITS-1:0] volume_t;

endpackage

// File: hdl/link_pkg.sv
// wire-link types: transmitter and receiver states,
// bit position within a word and the timing counters
`include "audio_link_config.svh"

package link_pkg;

  // transmitter sequence: data bits, then end pattern
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_DATA,
    TX_END
  } tx_state_t;

  // receiver waits for a strobe, then samples one bit
  typedef enum logic {
    RX_IDLE,
    RX_SAMPLING
  } rx_state_t;

  // position within an 8-bit word
  typedef logic [$clog2(`AUDIO_BITS)-1:0] bit_index_t;

  // clock count within one bit on the wire
  typedef logic [$clog2(`BIT_CYCLES)-1:0] bit_timer_t;

  // samples taken and ones seen within a sampling window
  typedef logic [$clog2(2 * `MAJORITY)-1:0] sample_count_t;

endpackage

// File: hdl/switch_debouncer.sv
// switch debouncer
// a change on the noisy input reaches clean only after
// the input has held the new level long enough
`include "audio_link_config.svh"

module switch_debouncer (
  input  logic clock,
  input  logic reset,
  input  logic noisy,
  output logic clean
);

  // counter must be able to hold the full stable count
  localparam int COUNT_BITS = $clog2(`DEBOUNCE_CYCLES + 1);

  // level waiting to prove itself stable
  logic                  candidate;
  logic [COUNT_BITS-1:0] stable_count;

  always_ff @(posedge clock) begin
    if (reset) begin
      // start out already settled on whatever the pin shows
      candidate    <= noisy;
      clean        <= noisy;
      stable_count <= '0;
    end else if (noisy != candidate) begin
      // input moved, restart the wait on the new level
      candidate    <= noisy;
      stable_count <= '0;
    end else if (stable_count == COUNT_BITS'(`DEBOUNCE_CYCLES)) begin
      // held long enough, pass it along
      clean <= candidate;
    end else begin
      stable_count <= stable_count + 1'b1;
    end
  end

endmodule

// File: hdl/volume_control.sv
// volume control
// two debounced buttons, rising edge detect, and a
// saturating up/down volume register
`include "audio_link_config.svh"

module volume_control (
  input  logic               clock,
  input  logic               reset,
  input  logic               button_up,
  input  logic               button_down,
  output audio_pkg::volume_t volume
);

  logic up_clean;
  logic down_clean;
  logic up_prev;
  logic down_prev;
  logic up_edge;
  logic down_edge;

  switch_debouncer i_debounce_up (
    .clock (clock),
    .reset (reset),
    .noisy (button_up),
    .clean (up_clean)
  );

  switch_debouncer i_debounce_down (
    .clock (clock),
    .reset (reset),
    .noisy (button_down),
    .clean (down_clean)
  );

  // only a fresh press counts, holding does not repeat
  assign up_edge   = up_clean & ~up_prev;
  assign down_edge = down_clean & ~down_prev;

  always_ff @(posedge clock) begin
    if (reset) begin
      // match the debouncer reset so a held button gives no edge
      up_prev   <= button_up;
      down_prev <= button_down;
      volume    <= audio_pkg::volume_t'(`VOLUME_RESET);
    end else begin
      up_prev   <= up_clean;
      down_prev <= down_clean;
      // down has priority when both edges land together
      if (down_edge) begin
        if (volume != '0)
          volume <= volume - 1'b1;
      end else if (up_edge && volume != audio_pkg::volume_t'(`VOLUME_MAX)) begin
        volume <= volume + 1'b1;
      end
    end
  end

endmodule

// File: hdl/link_transmitter.sv
// serial link transmitter
// latches sample xor key, sends 8 data bits lsb first with a
// strobe per bit, then an alternating end pattern without strobe
`include "audio_link_config.svh"

module link_transmitter (
  input  logic               clock,
  input  logic               reset,
  input  logic               sample_ready,
  input  audio_pkg::sample_t sample_in,
  input  audio_pkg::key_t    key,
  output logic               line_data,
  output logic               line_strobe
);

  localparam int STROBE_BITS = $clog2(`STROBE_CYCLES + 1);

  // 0,1,0,1... when shifted out lsb first
  localparam audio_pkg::sample_t END_PATTERN = {(`AUDIO_BITS / 2){2'b10}};

  localparam link_pkg::bit_timer_t LAST_CYCLE = link_pkg::bit_timer_t'(`BIT_CYCLES - 1);
  localparam link_pkg::bit_index_t LAST_BIT = '1;

  link_pkg::tx_state_t    state;
  link_pkg::bit_timer_t   bit_timer;
  link_pkg::bit_index_t   bit_index;
  audio_pkg::sample_t     shift;
  logic [STROBE_BITS-1:0] strobe_left;
  logic                   bit_done;

  assign bit_done = (bit_timer == LAST_CYCLE);

  //////////////////////////////////////////////////
  // bit sequencing
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= link_pkg::TX_IDLE;
      bit_timer <= '0;
      bit_index <= '0;
      // idle line sits low until the first word
      shift     <= '0;
    end else if (sample_ready) begin
      // new sample wins, any word in flight is dropped
      state     <= link_pkg::TX_DATA;
      bit_timer <= '0;
      bit_index <= '0;
      shift     <= sample_in ^ key;
    end else begin
      case (state)
        link_pkg::TX_DATA: begin
          bit_timer <= bit_done ? '0 : bit_timer + 1'b1;
          if (bit_done) begin
            bit_index <= bit_index + 1'b1;
            if (bit_index == LAST_BIT) begin
              state <= link_pkg::TX_END;
              shift <= END_PATTERN;
            end else begin
              shift <= shift >> 1;
            end
          end
        end
        link_pkg::TX_END: begin
          bit_timer <= bit_done ? '0 : bit_timer + 1'b1;
          if (bit_done) begin
            bit_index <= bit_index + 1'b1;
            // last end bit stays on the line while idle
            if (bit_index == LAST_BIT)
              state <= link_pkg::TX_IDLE;
            else
              shift <= shift >> 1;
          end
        end
        default: begin
          bit_timer <= '0;
          bit_index <= '0;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // strobe shaping
  //////////////////////////////////////////////////

  // load at the first clock of each data bit, so the strobe rises
  // one clock into the bit; never loaded in the end state
  always_ff @(posedge clock) begin
    if (reset) begin
      strobe_left <= '0;
    end else if (sample_ready) begin
      // cut a running strobe short on restart
      strobe_left <= '0;
    end else if (state == link_pkg::TX_DATA && bit_timer == '0) begin
      strobe_left <= STROBE_BITS'(`STROBE_CYCLES);
    end else if (strobe_left != '0) begin
      strobe_left <= strobe_left - 1'b1;
    end
  end

  assign line_strobe = (strobe_left != '0);
  assign line_data   = shift[0];

endmodule

// File: hdl/link_receiver.sv
// serial link receiver
// strobe qualification, majority sampling of each bit,
// end pattern detection and key removal on the finished word
`include "audio_link_config.svh"

module link_receiver (
  input  logic               clock,
  input  logic               reset,
  input  logic               rx_data,
  input  logic               rx_strobe,
  input  audio_pkg::key_t    key,
  output audio_pkg::sample_t sample_out,
  output logic               sample_valid
);

  localparam int SAMPLES     = 2 * `MAJORITY - 1;
  localparam int SETTLE      = `SETTLE_CYCLES;
  localparam int HIST_BITS   = 2 * SETTLE;
  localparam int TOGGLE_BITS = $clog2(`END_TOGGLES + 1);

  link_pkg::rx_state_t     state;
  logic [HIST_BITS-1:0]    strobe_hist;
  logic                    strobe_ok;
  link_pkg::sample_count_t sample_count;
  link_pkg::sample_count_t ones_count;
  link_pkg::bit_index_t    bit_index;
  audio_pkg::sample_t      word;
  audio_pkg::sample_t      word_next;
  logic                    bit_value;
  logic                    bit_done;
  logic                    data_prev;
  logic [TOGGLE_BITS-1:0]  toggle_count;
  logic                    end_seen;

  //////////////////////////////////////////////////
  // strobe qualification and end detection
  //////////////////////////////////////////////////

  // newest SETTLE samples high, the SETTLE before them low
  // a short glitch never fills the high half
  assign strobe_ok = (&strobe_hist[SETTLE-1:0]) & ~(|strobe_hist[HIST_BITS-1:SETTLE]);
  assign end_seen  = (toggle_count == TOGGLE_BITS'(`END_TOGGLES));

  always_ff @(posedge clock) begin
    if (reset) begin
      strobe_hist <= '0;
      data_prev   <= 1'b0;
    end else begin
      strobe_hist <= {strobe_hist[HIST_BITS-2:0], rx_strobe};
      data_prev   <= rx_data;
    end
  end

  // data toggles with no counted strobe in between
  // saturates, cleared by the next real strobe
  always_ff @(posedge clock) begin
    if (reset)
      toggle_count <= '0;
    else if (strobe_ok)
      toggle_count <= '0;
    else if (rx_data != data_prev && !end_seen)
      toggle_count <= toggle_count + 1'b1;
  end

  //////////////////////////////////////////////////
  // majority sampling and word assembly
  //////////////////////////////////////////////////

  assign bit_value = (ones_count >= link_pkg::sample_count_t'(`MAJORITY));
  assign bit_done  = (state == link_pkg::RX_SAMPLING) && !strobe_ok &&
                     (sample_count == link_pkg::sample_count_t'(SAMPLES));

  // word with the decided bit dropped into place
  always_comb begin
    word_next = word;
    word_next[bit_index] = bit_value;
  end

  always_ff @(posedge clock) begin
    if (bit_done)
      word <= word_next;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state        <= link_pkg::RX_IDLE;
      sample_count <= '0;
      ones_count   <= '0;
      bit_index    <= '0;
      sample_out   <= '0;
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= 1'b0;
      if (strobe_ok) begin
        // fresh window for this bit
        state        <= link_pkg::RX_SAMPLING;
        sample_count <= '0;
        ones_count   <= '0;
      end else if (bit_done) begin
        state     <= link_pkg::RX_IDLE;
        bit_index <= bit_index + 1'b1;
        // eighth bit in, hand out the word without the key
        if (bit_index == '1) begin
          sample_out   <= word_next ^ key;
          sample_valid <= 1'b1;
        end
      end else if (state == link_pkg::RX_SAMPLING) begin
        sample_count <= sample_count + 1'b1;
        ones_count   <= ones_count + rx_data;
      end
      // end pattern seen, realign to the start of the next word
      if (end_seen)
        bit_index <= '0;
    end
  end

endmodule

// File: hdl/audio_link_top.sv
// audio link top level
// volume control plus transmitter and receiver as peers,
// the wire loop is closed outside this block
module audio_link_top (
  input  logic               clock,
  input  logic               reset,
  // sample side
  input  audio_pkg::sample_t sample_in,
  input  logic               sample_ready,
  input  audio_pkg::key_t    key,
  // buttons
  input  logic               button_up,
  input  logic               button_down,
  // wire side, receive
  input  logic               rx_data,
  input  logic               rx_strobe,
  // wire side, transmit
  output logic               line_data,
  output logic               line_strobe,
  // recovered samples
  output audio_pkg::sample_t sample_out,
  output logic               sample_valid,
  output audio_pkg::volume_t volume
);

  //////////////////////////////////////////////////
  // volume
  //////////////////////////////////////////////////

  volume_control i_volume_control (
    .clock       (clock),
    .reset       (reset),
    .button_up   (button_up),
    .button_down (button_down),
    .volume      (volume)
  );

  //////////////////////////////////////////////////
  // serial link, both directions share one key
  //////////////////////////////////////////////////

  link_transmitter i_link_transmitter (
    .clock        (clock),
    .reset        (reset),
    .sample_ready (sample_ready),
    .sample_in    (sample_in),
    .key          (key),
    .line_data    (line_data),
    .line_strobe  (line_strobe)
  );

  link_receiver i_link_receiver (
    .clock        (clock),
    .reset        (reset),
    .rx_data      (rx_data),
    .rx_strobe    (rx_strobe),
    .key          (key),
    .sample_out   (sample_out),
    .sample_valid (sample_valid)
  );

endmodule

// File: verif/audio_link_asserts.sv
// concurrent checks on the audio link top level
// strobe length, single-cycle valid, volume upper limit
`include "audio_link_config.svh"

module audio_link_asserts (
  input logic               clock,
  input logic               reset,
  input logic               line_strobe,
  input logic               sample_valid,
  input audio_pkg::volume_t volume
);
  timeunit 1ns;
  timeprecision 100ps;

  // consecutive cycles the strobe has been seen high
  int strobe_run;
  // nonzero once any property below has failed
  int failure_count = 0;

  always_ff @(posedge clock) begin
    if (reset)
      strobe_run <= 0;
    else if (line_strobe)
      strobe_run <= strobe_run + 1;
    else
      strobe_run <= 0;
  end

  strobe_length: assert property (@(posedge clock) disable iff (reset)
      strobe_run <= `STROBE_CYCLES)
    else begin
      $error("line_strobe high for more than %0d cycles", `STROBE_CYCLES);
      failure_count++;
    end

  // a recovered word is announced in exactly one cycle
  valid_single: assert property (@(posedge clock) disable iff (reset)
      sample_valid |=> !sample_valid)
    else begin
      $error("sample_valid high for two cycles in a row");
      failure_count++;
    end

  // at the limit the level may only hold or step down, never wrap past it
  volume_limit: assert property (@(posedge clock) disable iff (reset)
      volume == `VOLUME_MAX |=> volume == `VOLUME_MAX || volume == `VOLUME_MAX - 1)
    else begin
      $error("volume went from %0d to %0d", `VOLUME_MAX, volume);
      failure_count++;
    end

endmodule

bind audio_link_top audio_link_asserts i_audio_link_asserts (
  .clock        (clock),
  .reset        (reset),
  .line_strobe  (line_strobe),
  .sample_valid (sample_valid),
  .volume       (volume)
);

// File: verif/audio_link_tb.sv
// testbench for the audio link top level
// table of words over a looped-back wire with optional glitches,
// then volume button presses, bounces and saturation
`include "audio_link_config.svh"

module audio_link_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_WORDS  = 8;
  localparam int WAIT_LIMIT = 4 * `BIT_CYCLES;
  localparam int PRESS_HOLD = 3 * `DEBOUNCE_CYCLES;
  // rest of the end pattern plus margin, keeps words far enough apart
  localparam int GAP_CYCLES = 9 * `BIT_CYCLES;
  localparam int GLITCH_BIT = 3;
  // middle of the five samples, which start once SETTLE highs are seen
  localparam int FLIP_DELAY = `SETTLE_CYCLES + `MAJORITY;
  // right after the strobe falls, leaving a clean low history
  localparam int SPIKE_DELAY = `STROBE_CYCLES + 1;

  typedef enum logic [1:0] {GLITCH_NONE, GLITCH_DATA, GLITCH_STROBE} glitch_t;

  typedef struct packed {
    logic               use_random;
    audio_pkg::sample_t sample;
    audio_pkg::key_t    key;
    glitch_t            glitch;
    audio_pkg::sample_t expected;
  } word_entry_t;

  // random entries get sample and expected value at run time
  localparam word_entry_t WORD_TABLE [NUM_WORDS] = '{
    '{1'b0, 8'h00, 8'h00, GLITCH_NONE,   8'h00},
    '{1'b0, 8'hA5, 8'h00, GLITCH_NONE,   8'hA5},
    '{1'b0, 8'h3C, 8'h5A, GLITCH_NONE,   8'h3C},
    '{1'b0, 8'hFF, 8'hC3, GLITCH_DATA,   8'hFF},
    '{1'b0, 8'h81, 8'h69, GLITCH_STROBE, 8'h81},
    '{1'b1, 8'h00, 8'h96, GLITCH_NONE,   8'h00},
    '{1'b1, 8'h00, 8'h00, GLITCH_DATA,   8'h00},
    '{1'b0, 8'h5A, 8'hFF, GLITCH_STROBE, 8'h5A}
  };

  logic               clock = 1'b0;
  logic               reset;
  audio_pkg::sample_t sample_in;
  logic               sample_ready;
  audio_pkg::key_t    key;
  logic               button_up;
  logic               button_down;
  logic               rx_data;
  logic               rx_strobe;
  logic               line_data;
  logic               line_strobe;
  audio_pkg::sample_t sample_out;
  logic               sample_valid;
  audio_pkg::volume_t volume;
  // disturbances added on the way back to the receiver
  logic               data_flip;
  logic               strobe_spike;
  integer             random_seed;

  always #4 clock = ~clock;

  // external loopback of the wire
  assign rx_data   = line_data ^ data_flip;
  assign rx_strobe = line_strobe | strobe_spike;

  audio_link_top i_audio_link_top (.*);

  //////////////////////////////////////////////////
  // checking and waiting
  //////////////////////////////////////////////////

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
      fail_run($sformatf("** Error at %0t ns: %s = 0x%0h, expected 0x%0h",
                         $time, name, actual, expected));
  endtask

  task automatic wait_for_strobe(input logic level);
    int cycles = 0;
    @(negedge clock);
    while (line_strobe !== level) begin
      cycles++;
      if (cycles > WAIT_LIMIT)
        fail_run($sformatf("timeout: line_strobe never went to %0b", level));
      @(negedge clock);
    end
  endtask

  task automatic wait_for_valid();
    int cycles = 0;
    @(negedge clock);
    while (sample_valid !== 1'b1) begin
      cycles++;
      if (cycles > WAIT_LIMIT)
        fail_run("timeout: sample_valid never pulsed after a word");
      @(negedge clock);
    end
  endtask

  task automatic wait_for_volume(input audio_pkg::volume_t expected);
    int cycles = 0;
    @(negedge clock);
    while (volume !== expected) begin
      cycles++;
      if (cycles > 4 * `DEBOUNCE_CYCLES)
        fail_run($sformatf("timeout: volume never reached %0d", expected));
      @(negedge clock);
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  // called one clock after the strobe rises
  task automatic inject_glitch(input glitch_t kind);
    if (kind == GLITCH_DATA) begin
      repeat (FLIP_DELAY) @(posedge clock);
      data_flip <= 1'b1;
      @(posedge clock);
      data_flip <= 1'b0;
    end else if (kind == GLITCH_STROBE) begin
      // two cycles, too short to count as a strobe
      repeat (SPIKE_DELAY) @(posedge clock);
      strobe_spike <= 1'b1;
      repeat (2) @(posedge clock);
      strobe_spike <= 1'b0;
    end
  endtask

  task automatic send_word(input word_entry_t entry);
    audio_pkg::sample_t sample;
    audio_pkg::sample_t expected;
    audio_pkg::sample_t coded;
    int                 strobe_cycles;
    int                 extra_valid;
    sample   = entry.sample;
    expected = entry.expected;
    if (entry.use_random) begin
      sample   = audio_pkg::sample_t'($random(random_seed));
      expected = sample;
    end
    // bits on the wire carry the key
    coded = sample ^ entry.key;
    @(posedge clock);
    sample_in    <= sample;
    key          <= entry.key;
    sample_ready <= 1'b1;
    @(posedge clock);
    sample_ready <= 1'b0;
    // eight strobes, lsb first, data read while the strobe is high
    for (int i = 0; i < `AUDIO_BITS; i++) begin
      wait_for_strobe(1'b1);
      check_value($sformatf("line_data bit %0d", i), line_data, coded[i]);
      if (i == GLITCH_BIT)
        inject_glitch(entry.glitch);
      wait_for_strobe(1'b0);
    end
    wait_for_valid();
    check_value("sample_out", sample_out, expected);
    // end pattern runs strobe-free, no second word appears
    strobe_cycles = 0;
    extra_valid   = 0;
    repeat (GAP_CYCLES) begin
      @(negedge clock);
      strobe_cycles += int'(line_strobe);
      extra_valid   += int'(sample_valid);
    end
    check_value("line_strobe cycles in end pattern", strobe_cycles, 0);
    check_value("extra sample_valid pulses", extra_valid, 0);
    // pattern 0,1,0,1... leaves a one on the idle line
    check_value("line_data at idle", line_data, 1);
  endtask

  // down wins over up, both ends saturate
  function automatic audio_pkg::volume_t step_volume(input audio_pkg::volume_t level,
                                                     input logic up, input logic down);
    if (down)
      return (level == 0) ? level : audio_pkg::volume_t'(level - 1);
    if (up)
      return (level == `VOLUME_MAX) ? level : audio_pkg::volume_t'(level + 1);
    return level;
  endfunction

  task automatic press_buttons(input logic up, input logic down,
                               input audio_pkg::volume_t expected);
    @(posedge clock);
    button_up   <= up;
    button_down <= down;
    wait_for_volume(expected);
    repeat (PRESS_HOLD) @(posedge clock);
    button_up   <= 1'b0;
    button_down <= 1'b0;
    repeat (PRESS_HOLD) @(posedge clock);
    @(negedge clock);
    check_value("volume after release", volume, expected);
  endtask

  // a few short spikes, none held for the debounce count
  task automatic bounce_up();
    repeat (3) begin
      @(posedge clock);
      button_up <= 1'b1;
      repeat (`DEBOUNCE_CYCLES / 2) @(posedge clock);
      button_up <= 1'b0;
      repeat (`DEBOUNCE_CYCLES / 4) @(posedge clock);
    end
    repeat (PRESS_HOLD) @(posedge clock);
  endtask

  //////////////////////////////////////////////////
  // sequence
  //////////////////////////////////////////////////

  initial begin
    audio_pkg::volume_t expected_volume;
    random_seed  = 32'h6de8_0fe9;
    reset        <= 1'b1;
    sample_in    <= '0;
    sample_ready <= 1'b0;
    key          <= '0;
    button_up    <= 1'b0;
    button_down  <= 1'b0;
    data_flip    <= 1'b0;
    strobe_spike <= 1'b0;
    repeat (8) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    check_value("line_strobe", line_strobe, 0);
    check_value("line_data", line_data, 0);
    check_value("sample_valid", sample_valid, 0);
    check_value("sample_out", sample_out, 0);
    check_value("volume", volume, `VOLUME_RESET);

    for (int i = 0; i < NUM_WORDS; i++)
      send_word(WORD_TABLE[i]);

    expected_volume = `VOLUME_RESET;
    bounce_up();
    @(negedge clock);
    check_value("volume after bounce", volume, expected_volume);
    // climb past the top
    repeat (`VOLUME_MAX - `VOLUME_RESET + 3) begin
      expected_volume = step_volume(expected_volume, 1'b1, 1'b0);
      press_buttons(1'b1, 1'b0, expected_volume);
    end
    check_value("volume at top", volume, `VOLUME_MAX);
    expected_volume = step_volume(expected_volume, 1'b1, 1'b1);
    press_buttons(1'b1, 1'b1, expected_volume);
    // descend past zero
    repeat (`VOLUME_MAX + 2) begin
      expected_volume = step_volume(expected_volume, 1'b0, 1'b1);
      press_buttons(1'b0, 1'b1, expected_volume);
    end
    check_value("volume at bottom", volume, 0);

    if (i_audio_link_top.i_audio_link_asserts.failure_count != 0) begin
      fail_run("a bound assertion failed during the run");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

// File: compile.f
+incdir+hdl
hdl/audio_pkg.sv
hdl/link_pkg.sv
hdl/switch_debouncer.sv
hdl/volume_control.sv
hdl/link_transmitter.sv
hdl/link_receiver.sv
hdl/audio_link_top.sv
verif/audio_link_asserts.sv
verif/audio_link_tb.sv

// File: Makefile
# verilator flow for the audio link testbench
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR   ?= verilator
TOP         ?= audio_link_tb
FILE_LIST   ?= compile.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
BUILD_FLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS  ?= --lint-only --timing -Wall
SIM_ARGS    ?= +verilator+error+limit+1000
PASS_TEXT   ?= ** PASS **

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

sim: build
	./$(BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -qF -- '$(PASS_TEXT)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
